/* tb.f */
hdl/cpu_pkg.sv
hdl/regfile.sv
hdl/decode.sv
hdl/hazard_control.sv
hdl/alu_stage.sv
hdl/mult_pipe.sv
hdl/writeback.sv
hdl/cpu_core.sv
verif/cpu_tb_asserts.sv
verif/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f tb.f --top-module cpu_tb -o cpu_tb_sim \
   && ./obj_dir/cpu_tb_sim | tee /dev/stderr | grep "all tests passed" > /dev/null \
   && echo "run.sh: simulation PASS" \
   || { echo "run.sh: simulation FAIL"; exit 1; }

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

   localparam int N_TESTS     = 29;
   localparam int RAW_FIRST   = 16;  // Dependency chain and WAW pair
   localparam int RAW_LAST    = 22;
   localparam int STALL_LIMIT = 40;
   localparam int DRAIN_LIMIT = 100;

   logic    clk;
   logic    if_id_reset;
   logic    instr_valid;
   instr_t  instr;
   logic    stall;
   result_t wb;

   // Stimulus table, expected values from in-order execution
   string     names [N_TESTS];
   instr_t    words [N_TESTS];
   reg_addr_t dests [N_TESTS];  // 0 means no writeback
   word_t     exps  [N_TESTS];
   bit        burst [N_TESTS];  // No idle gap after this entry
   int        n_entries;

   int pend [$];  // Accepted table indices, oldest first
   int mismatches;
   int unexpected;
   int timeouts;
   int wb_count;
   int raw_stalls;

   cpu_core DUT (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .stall       (stall),
      .wb          (wb)
   );

   always #20 clk = ~clk;

   function automatic instr_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     logic [5:0] fn);
      instr_t w;
      w.r = {OP_RTYPE, rs, rt, rd, 5'd0, fn};
      return w;
   endfunction

   function automatic instr_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
      instr_t w;
      w.i = {op, rs, rt, imm};
      return w;
   endfunction

   function automatic bit is_mul_word(instr_t w);
      return w.r.opcode == OP_RTYPE && w.r.funct == FN_MUL;
   endfunction

   task automatic add_entry(string name, instr_t w, reg_addr_t d, word_t e, bit b);
      names[n_entries] = name;
      words[n_entries] = w;
      dests[n_entries] = d;
      exps[n_entries]  = e;
      burst[n_entries] = b;
      n_entries++;
   endtask

   task automatic load_table();
      add_entry("ori_base", i_type(OP_ORI, 5'd0, 5'd1, 16'h1234), 5'd1, 32'h0000_1234, 1'b0);
      add_entry("ori_zext", i_type(OP_ORI, 5'd0, 5'd2, 16'hffff), 5'd2, 32'h0000_ffff, 1'b0);
      add_entry("addi_sext", i_type(OP_ADDI, 5'd0, 5'd3, 16'hfffb), 5'd3, 32'hffff_fffb, 1'b0);
      add_entry("addi_pos", i_type(OP_ADDI, 5'd0, 5'd4, 16'h7fff), 5'd4, 32'h0000_7fff, 1'b0);
      add_entry("add", r_type(5'd1, 5'd2, 5'd5, FN_ADD), 5'd5, 32'h0001_1233, 1'b0);
      add_entry("sub", r_type(5'd1, 5'd2, 5'd6, FN_SUB), 5'd6, 32'hffff_1235, 1'b0);
      add_entry("and", r_type(5'd1, 5'd2, 5'd7, FN_AND), 5'd7, 32'h0000_1234, 1'b0);
      add_entry("or", r_type(5'd3, 5'd1, 5'd8, FN_OR), 5'd8, 32'hffff_ffff, 1'b0);
      add_entry("add_wrap", r_type(5'd8, 5'd1, 5'd9, FN_ADD), 5'd9, 32'h0000_1233, 1'b0);
      // Back-to-back multiplies with ALU ops in between
      add_entry("mul_a", r_type(5'd1, 5'd2, 5'd11, FN_MUL), 5'd11, 32'h1233_edcc, 1'b1);
      add_entry("mul_neg", r_type(5'd3, 5'd4, 5'd12, FN_MUL), 5'd12, 32'hfffd_8005, 1'b1);
      add_entry("add_mid", r_type(5'd1, 5'd4, 5'd13, FN_ADD), 5'd13, 32'h0000_9233, 1'b1);
      add_entry("mul_sq", r_type(5'd4, 5'd4, 5'd14, FN_MUL), 5'd14, 32'h3fff_0001, 1'b1);
      add_entry("or_mid", r_type(5'd2, 5'd4, 5'd15, FN_OR), 5'd15, 32'h0000_ffff, 1'b1);
      add_entry("mul_ones", r_type(5'd8, 5'd8, 5'd16, FN_MUL), 5'd16, 32'h0000_0001, 1'b1);
      add_entry("sub_mid", r_type(5'd4, 5'd1, 5'd17, FN_SUB), 5'd17, 32'h0000_6dcb, 1'b1);
      add_entry("raw_addi", i_type(OP_ADDI, 5'd1, 5'd18, 16'h0001), 5'd18, 32'h0000_1235, 1'b1);
      add_entry("raw_mul", r_type(5'd18, 5'd18, 5'd19, FN_MUL), 5'd19, 32'h014b_7ef9, 1'b1);
      add_entry("raw_add", r_type(5'd19, 5'd18, 5'd20, FN_ADD), 5'd20, 32'h014b_912e, 1'b1);
      add_entry("raw_sub", r_type(5'd20, 5'd1, 5'd21, FN_SUB), 5'd21, 32'h014b_7efa, 1'b1);
      add_entry("waw_mul", r_type(5'd4, 5'd2, 5'd22, FN_MUL), 5'd22, 32'h7ffe_8001, 1'b1);
      add_entry("waw_ori", i_type(OP_ORI, 5'd0, 5'd22, 16'h00aa), 5'd22, 32'h0000_00aa, 1'b1);
      add_entry("waw_read", r_type(5'd22, 5'd1, 5'd23, FN_ADD), 5'd23, 32'h0000_12de, 1'b1);
      // None of these four may write back
      add_entry("r0_add", r_type(5'd1, 5'd2, 5'd0, FN_ADD), 5'd0, 32'h0, 1'b0);
      add_entry("r0_ori", i_type(OP_ORI, 5'd0, 5'd0, 16'h5555), 5'd0, 32'h0, 1'b0);
      add_entry("bad_opcode", i_type(6'h23, 5'd1, 5'd24, 16'h0010), 5'd0, 32'h0, 1'b0);
      add_entry("bad_funct", r_type(5'd1, 5'd2, 5'd25, 6'h2a), 5'd0, 32'h0, 1'b0);
      add_entry("r0_read_add", r_type(5'd0, 5'd1, 5'd24, FN_ADD), 5'd24, 32'h0000_1234, 1'b0);
      add_entry("r0_read_sub", r_type(5'd0, 5'd3, 5'd26, FN_SUB), 5'd26, 32'h0000_0005, 1'b0);
   endtask

   task automatic check_word(string name, word_t expected, word_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic check_reg(string name, reg_addr_t expected, reg_addr_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s: expected r%0d, actual r%0d", name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic check_bit(string name, logic expected, logic actual);
      if (actual !== expected) begin
         $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic print_summary();
      $display("errors: %0d mismatches, %0d unexpected events, %0d timeouts",
               mismatches, unexpected, timeouts);
   endtask

   task automatic take_writeback(result_t r);
      int hit;
      int first;
      hit   = -1;
      first = -1;
      wb_count++;
      foreach (pend[k]) begin
         if (hit < 0 && dests[pend[k]] == r.dest) hit = k;
      end
      if (hit < 0) begin
         $display("writeback to r%0d arrived with no instruction pending for it", r.dest);
         unexpected++;
      end else begin
         foreach (pend[k]) begin
            if (first < 0 && is_mul_word(words[pend[k]]) == is_mul_word(words[pend[hit]]))
               first = k;
         end
         // Each path on its own retires in acceptance order
         check_reg(names[pend[hit]], dests[pend[first]], r.dest);
         check_word(names[pend[hit]], exps[pend[hit]], r.data);
         pend.delete(hit);
      end
   endtask

   always @(negedge clk) begin
      if (if_id_reset === 1'b0 && wb.valid === 1'b1) take_writeback(wb);
   end

   task automatic reset_cycle(bit last);
      @(posedge clk);
      if (last) if_id_reset <= 1'b0;
      @(negedge clk);
      check_bit("reset_wb_valid", 1'b0, wb.valid);
      check_bit("reset_stall", 1'b0, stall);
   endtask

   // Present one entry and hold it until the accepting edge
   task automatic send(int idx);
      int waited;
      waited = 0;
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= words[idx];
      @(negedge clk);
      while (stall !== 1'b0 && waited < STALL_LIMIT) begin
         // A stall here holds the previous entry in IF/ID
         if (idx > RAW_FIRST && idx <= RAW_LAST + 1) raw_stalls++;
         @(negedge clk);
         waited++;
      end
      if (stall !== 1'b0) begin
         $display("timed out waiting for stall to clear before %s", names[idx]);
         timeouts++;
      end else if (dests[idx] != '0) begin
         pend.push_back(idx);
      end
   endtask

   task automatic idle(int cycles);
      @(posedge clk);
      instr_valid <= 1'b0;
      repeat (cycles - 1) @(posedge clk);
   endtask

   initial begin
      int gap;
      int waited;
      int exp_wb;
      void'($urandom(32'hce90_49f0));
      clk         = 1'b0;
      if_id_reset = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      load_table();
      for (int c = 0; c < 16; c++) reset_cycle(c == 15);
      repeat (4) begin
         @(negedge clk);
         check_bit("idle_wb_valid", 1'b0, wb.valid);
         check_bit("idle_stall", 1'b0, stall);
      end
      for (int i = 0; i < n_entries && timeouts == 0; i++) begin
         send(i);
         gap = burst[i] ? 0 : $urandom % 3;
         if (gap > 0) idle(gap);
      end
      idle(1);
      waited = 0;
      while (timeouts == 0 && pend.size() != 0 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (timeouts == 0 && pend.size() != 0) begin
         $display("timed out waiting for all pending writebacks to drain");
         timeouts++;
      end
      repeat (10) @(negedge clk);  // Window for stray writebacks
      if (raw_stalls == 0) begin
         $display("stall never went high during the dependency chain");
         unexpected++;
      end
      exp_wb = 0;
      for (int i = 0; i < n_entries; i++) begin
         if (dests[i] != '0) exp_wb++;
      end
      if (wb_count != exp_wb) begin
         $display("MISMATCH writeback_count: expected %0d, actual %0d", exp_wb, wb_count);
         mismatches++;
      end
      print_summary();
      if (mismatches + unexpected + timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* verif/cpu_tb_asserts.sv */
`timescale 1ns/1ps

module cpu_tb_asserts import cpu_pkg::*; (
   input logic    clk,
   input logic    if_id_reset,
   input result_t alu_res,
   input result_t mul_res,
   input result_t wb
);

   // Hazard control keeps the two result paths apart
   one_source: assert property (@(posedge clk) disable iff (if_id_reset)
      !(alu_res.valid && mul_res.valid))
      else $error("ALU and multiply results valid in the same cycle");

   wb_dest_nonzero: assert property (@(posedge clk) disable iff (if_id_reset)
      wb.valid |-> wb.dest != '0)
      else $error("writeback aimed at register 0");

   wb_clear_after_reset: assert property (@(posedge clk) if_id_reset |=> !wb.valid)
      else $error("writeback valid in the cycle after reset");

endmodule

bind writeback cpu_tb_asserts u_asserts (
   .clk         (clk),
   .if_id_reset (if_id_reset),
   .alu_res     (alu_res),
   .mul_res     (mul_res),
   .wb          (wb)
);

/* hdl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
   input  logic    clk,
   input  logic    if_id_reset,
   input  logic    instr_valid,
   input  instr_t  instr,
   output logic    stall,
   output result_t wb
);

   issue_t       issue;
   reg_addr_t    rs_a;
   reg_addr_t    rs_b;
   result_t      alu_res;
   result_t      mul_res;
   pipe_status_t status;

   decode u_decode (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .stall       (stall),
      .wr          (wb),          // Writeback register feeds the regfile
      .rs_a        (rs_a),
      .rs_b        (rs_b),
      .issue       (issue)
   );

   hazard_control u_hazard_control (
      .rs_a   (rs_a),
      .rs_b   (rs_b),
      .issue  (issue),
      .status (status),
      .stall  (stall)
   );

   alu_stage u_alu_stage (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .issue       (issue),
      .stall       (stall),
      .alu_res     (alu_res),
      .alu_status  (status.alu)
   );

   mult_pipe u_mult_pipe (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .issue       (issue),
      .stall       (stall),
      .mul_res     (mul_res),
      .mul_status  (status.mul)
   );

   writeback u_writeback (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .alu_res     (alu_res),
      .mul_res     (mul_res),
      .wb          (wb)
   );

endmodule

/* hdl/writeback.sv */
`timescale 1ns/1ps

module writeback import cpu_pkg::*; (
   input  logic    clk,
   input  logic    if_id_reset,
   input  result_t alu_res,
   input  result_t mul_res,
   output result_t wb
);

   // Hazard control keeps the two sources apart
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         wb.valid <= 1'b0;
      end else if (alu_res.valid) begin
         wb <= alu_res;
      end else begin
         wb <= mul_res;  // Also loads an idle slot
      end
   end

endmodule

/* hdl/mult_pipe.sv */
`timescale 1ns/1ps

module mult_pipe import cpu_pkg::*; (
   input  logic                        clk,
   input  logic                        if_id_reset,
   input  issue_t                      issue,
   input  logic                        stall,
   output result_t                     mul_res,
   output dest_slot_t [MUL_STAGES-1:0] mul_status
);

   dest_slot_t [MUL_STAGES-1:0] stage_q;
   word_t                       prod_q [MUL_STAGES];

   // Control side of the pipe
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int k = 0; k < MUL_STAGES; k++) begin
            stage_q[k].valid <= 1'b0;
         end
      end else begin
         stage_q[0].valid <= issue.valid && issue.is_mul && !stall;
         stage_q[0].dest  <= issue.dest;
         for (int k = 1; k < MUL_STAGES; k++) begin
            stage_q[k] <= stage_q[k-1];
         end
      end
   end

   // Low word of the product, carried alongside
   always_ff @(posedge clk) begin
      prod_q[0] <= issue.operand_a * issue.operand_b;
      for (int k = 1; k < MUL_STAGES; k++) begin
         prod_q[k] <= prod_q[k-1];
      end
   end

   assign mul_res.valid = stage_q[MUL_STAGES-1].valid;
   assign mul_res.dest  = stage_q[MUL_STAGES-1].dest;
   assign mul_res.data  = prod_q[MUL_STAGES-1];
   assign mul_status    = stage_q;

endmodule

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage import cpu_pkg::*; (
   input  logic       clk,
   input  logic       if_id_reset,
   input  issue_t     issue,
   input  logic       stall,
   output result_t    alu_res,
   output dest_slot_t alu_status
);

   issue_t ex_q;  // ID/EX register

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         ex_q.valid <= 1'b0;
      end else begin
         ex_q       <= issue;
         ex_q.valid <= issue.valid && !issue.is_mul && !stall;  // Bubble on stall
      end
   end

   always_comb begin
      alu_res.valid = ex_q.valid;
      alu_res.dest  = ex_q.dest;
      case (ex_q.alu_op)
         ALU_ADD: alu_res.data = ex_q.operand_a + ex_q.operand_b;  // Wraps
         ALU_SUB: alu_res.data = ex_q.operand_a - ex_q.operand_b;
         ALU_AND: alu_res.data = ex_q.operand_a & ex_q.operand_b;
         ALU_OR:  alu_res.data = ex_q.operand_a | ex_q.operand_b;
         default: alu_res.data = '0;
      endcase
   end

   assign alu_status.valid = ex_q.valid;
   assign alu_status.dest  = ex_q.dest;

endmodule

/* hdl/hazard_control.sv */
`timescale 1ns/1ps

module hazard_control import cpu_pkg::*; (
   input  reg_addr_t    rs_a,
   input  reg_addr_t    rs_b,
   input  issue_t       issue,
   input  pipe_status_t status,
   output logic         stall
);

   logic dep_hit;
   logic slot_clash;

   // RAW on either source or WAW on the destination
   function automatic logic slot_hits(dest_slot_t s, reg_addr_t a, reg_addr_t b,
                                      reg_addr_t d);
      return s.valid && (s.dest != '0) && (s.dest == a || s.dest == b || s.dest == d);
   endfunction

   always_comb begin
      dep_hit = slot_hits(status.alu, rs_a, rs_b, issue.dest);
      for (int k = 0; k < MUL_STAGES; k++) begin
         dep_hit = dep_hit | slot_hits(status.mul[k], rs_a, rs_b, issue.dest);
      end
   end

   // Entry one step before the last multiply register reaches writeback
   // together with an ALU op issued now
   assign slot_clash = !issue.is_mul && status.mul[MUL_STAGES-2].valid;

   // issue.valid already covers IF/ID valid, known opcode and nonzero dest
   assign stall = issue.valid && (dep_hit || slot_clash);

endmodule

/* hdl/decode.sv */
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
   input  logic      clk,
   input  logic      if_id_reset,
   input  logic      instr_valid,
   input  instr_t    instr,
   input  logic      stall,
   input  result_t   wr,
   output reg_addr_t rs_a,
   output reg_addr_t rs_b,
   output issue_t    issue
);

   logic   if_id_valid;
   instr_t if_id_instr;
   logic   known;
   word_t  rd_data_a;
   word_t  rd_data_b;

   // IF/ID register, held while stalled
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         if_id_valid <= 1'b0;
      end else if (!stall) begin
         if_id_valid <= instr_valid;
         if_id_instr <= instr;
      end
   end

   assign rs_a = if_id_instr.r.rs;
   assign rs_b = (if_id_instr.r.opcode == OP_RTYPE) ? if_id_instr.r.rt : '0;  // rt is dest for I-type

   regfile u_regfile (
      .clk       (clk),
      .rd_addr_a (rs_a),
      .rd_addr_b (rs_b),
      .wr        (wr),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

   always_comb begin
      known           = 1'b0;
      issue.is_mul    = 1'b0;
      issue.alu_op    = ALU_NONE;
      issue.dest      = '0;
      issue.operand_a = rd_data_a;
      issue.operand_b = rd_data_b;
      case (if_id_instr.r.opcode)
         OP_RTYPE: begin
            issue.dest = if_id_instr.r.rd;
            known      = 1'b1;
            case (if_id_instr.r.funct)
               FN_ADD:  issue.alu_op = ALU_ADD;
               FN_SUB:  issue.alu_op = ALU_SUB;
               FN_AND:  issue.alu_op = ALU_AND;
               FN_OR:   issue.alu_op = ALU_OR;
               FN_MUL:  issue.is_mul = 1'b1;
               default: known = 1'b0;
            endcase
         end
         OP_ADDI: begin
            known           = 1'b1;
            issue.dest      = if_id_instr.i.rt;
            issue.alu_op    = ALU_ADD;
            issue.operand_b = {{(WORD_W-16){if_id_instr.i.imm[15]}}, if_id_instr.i.imm};
         end
         OP_ORI: begin
            known           = 1'b1;
            issue.dest      = if_id_instr.i.rt;
            issue.alu_op    = ALU_OR;
            issue.operand_b = {{(WORD_W-16){1'b0}}, if_id_instr.i.imm};  // Zero-extended
         end
         default: known = 1'b0;
      endcase
      // Unknown or r0-bound instructions retire silently
      issue.valid = if_id_valid && known && (issue.dest != '0);
   end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
   input  logic      clk,
   input  reg_addr_t rd_addr_a,
   input  reg_addr_t rd_addr_b,
   input  result_t   wr,
   output word_t     rd_data_a,
   output word_t     rd_data_b
);

   // Register 0 has no storage
   word_t regs [1:(2**REG_ADDR_W)-1];

   function automatic word_t read_port(reg_addr_t addr, result_t w, word_t stored);
      if (addr == '0) begin
         return '0;
      end else if (w.valid && w.dest == addr) begin
         return w.data;  // Write-through
      end
      return stored;
   endfunction

   always_ff @(posedge clk) begin
      if (wr.valid && wr.dest != '0) begin
         regs[wr.dest] <= wr.data;
      end
   end

   assign rd_data_a = read_port(rd_addr_a, wr, (rd_addr_a != '0) ? regs[rd_addr_a] : '0);
   assign rd_data_b = read_port(rd_addr_b, wr, (rd_addr_b != '0) ? regs[rd_addr_b] : '0);

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

   localparam int WORD_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int MUL_STAGES = 5;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Major opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_ORI   = 6'h0d;

   // R-type function codes
   localparam logic [5:0] FN_ADD = 6'h20;
   localparam logic [5:0] FN_SUB = 6'h22;
   localparam logic [5:0] FN_AND = 6'h24;
   localparam logic [5:0] FN_OR  = 6'h25;
   localparam logic [5:0] FN_MUL = 6'h18;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_NONE
   } alu_op_t;

   typedef struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_view_t;

   typedef struct packed {
      logic [5:0]  opcode;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
   } i_view_t;

   // Same 32-bit word seen as R or I format
   typedef union packed {
      r_view_t r;
      i_view_t i;
   } instr_t;

   typedef struct packed {
      logic    valid;
      logic    is_mul;
      alu_op_t alu_op;
      reg_addr_t dest;
      word_t   operand_a;
      word_t   operand_b;  // Immediate already extended here
   } issue_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t dest;
      word_t     data;
   } result_t;

   // One destination still in flight
   typedef struct packed {
      logic      valid;
      reg_addr_t dest;
   } dest_slot_t;

   typedef struct packed {
      dest_slot_t                  alu;
      dest_slot_t [MUL_STAGES-1:0] mul;
   } pipe_status_t;

endpackage
